// File: compile.f
source/ramio_pkg.sv
source/ram_if.sv
source/bit_timer.sv
source/lane_steer.sv
source/word_ram.sv
source/uart_tx.sv
source/uart_rx.sv
source/ramio.sv
tests/tb_clock.sv
tests/ramio_sva.sv
tests/ramio_tb.sv

// File: tests/ramio_tb.sv
// testbench for the memory-mapped port
// applies a table of sized loads and stores against a reference memory,
// then loops the UART back onto itself and polls the I/O registers
`timescale 1ns/1ps
`default_nettype none

module ramio_tb import ramio_pkg::*; ();

  localparam int period       = 40;
  localparam int clks_per_bit = 8;
  localparam int frame_cycles = 10 * clks_per_bit;
  localparam logic [2:0] rd_word = {1'b0, size_word};

  // one access, stores always take LFSR data
  typedef struct {
    string       name;
    logic [2:0]  rd;
    size_e       wr;
    logic [31:0] addr;
    logic [31:0] data;
    bit          rnd;
    logic [31:0] exp;
    bit          use_model;
  } entry_t;

  wire         clk;
  wire         rst_n;
  logic        enable;
  logic [2:0]  read_type;
  size_e       write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  wire  [31:0] data_out;
  wire         data_out_ready;
  wire  [3:0]  led;
  wire         uart_line;

  entry_t      stim[$];
  logic [31:0] model_mem [32];
  logic [3:0]  led_model;
  logic [31:0] lfsr_state;
  bit          table_built = 1'b0;

  tb_clock #(.period(period), .reset_cycles(4)) clock_gen (
    .clk(clk),
    .rst_n(rst_n)
  );

  // transmit line feeds straight back into the receiver
  ramio #(.clks_per_bit(clks_per_bit)) dut (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .read_type(read_type),
    .write_type(write_type),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .led(led),
    .uart_tx(uart_line),
    .uart_rx(uart_line)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic bit is_io_addr(input logic [31:0] addr);
    return (addr == addr_led) || (addr == addr_uart_out) || (addr == addr_uart_in);
  endfunction

  // expected load from the reference words, misaligned gives 0
  function automatic logic [31:0] model_load(input logic [2:0] rd, input logic [31:0] addr);
    logic [31:0] word;
    logic [1:0]  off;
    logic [7:0]  b;
    logic [15:0] h;
    word = model_mem[addr[6:2]];
    off  = addr[1:0];
    b    = word[8*off +: 8];
    h    = off[1] ? word[31:16] : word[15:0];
    case (rd[1:0])
      size_byte: return rd[2] ? {{24{b[7]}}, b} : {24'b0, b};
      size_half: begin
        if (off[0]) begin
          return 32'h0;
        end
        return rd[2] ? {{16{h[15]}}, h} : {16'b0, h};
      end
      size_word: return (off == 2'b00) ? word : 32'h0;
      default:   return 32'h0;
    endcase
  endfunction

  task automatic model_store(input size_e wr, input logic [31:0] addr,
                             input logic [31:0] data);
    logic [4:0] w;
    logic [1:0] off;
    w   = addr[6:2];
    off = addr[1:0];
    case (wr)
      size_byte: model_mem[w][8*off +: 8] = data[7:0];
      size_half: begin
        if (!off[0]) begin
          model_mem[w][16*off[1] +: 16] = data[15:0];
        end
      end
      size_word: begin
        if (off == 2'b00) begin
          model_mem[w] = data;
        end
      end
      default: ;
    endcase
  endtask

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic add_store(input string name, input size_e wr, input logic [31:0] addr);
    entry_t e;
    e.name      = name;
    e.rd        = 3'b000;
    e.wr        = wr;
    e.addr      = addr;
    e.data      = 32'h0;
    e.rnd       = 1'b1;
    e.exp       = 32'h0;
    e.use_model = 1'b0;
    stim.push_back(e);
  endtask

  task automatic add_load(input string name, input logic [2:0] rd, input logic [31:0] addr,
                          input bit use_model, input logic [31:0] exp);
    entry_t e;
    e.name      = name;
    e.rd        = rd;
    e.wr        = size_none;
    e.addr      = addr;
    e.data      = 32'h0;
    e.rnd       = 1'b0;
    e.exp       = exp;
    e.use_model = use_model;
    stim.push_back(e);
  endtask

  task automatic build_table();
    size_e sizes[3];
    string tag;
    sizes = '{size_byte, size_half, size_word};
    add_load("reset led", rd_word, addr_led, 1'b0, 32'h0000_000f);
    add_load("reset uart out", rd_word, addr_uart_out, 1'b0, io_idle);
    add_load("reset uart in", rd_word, addr_uart_in, 1'b0, io_idle);
    // every model word gets written before any load sees it
    for (int w = 0; w < 32; w++) begin
      add_store($sformatf("fill word %0d", w), size_word, w * 4);
    end
    for (int off = 0; off < 4; off++) begin
      add_store($sformatf("store byte off %0d", off), size_byte, 32'h4 + off);
    end
    add_store("store half off 0", size_half, 32'h8);
    add_store("store half off 2", size_half, 32'ha);
    add_store("store word", size_word, 32'hc);
    // word 4 only sees misaligned stores
    add_store("misaligned half off 1", size_half, 32'h11);
    add_store("misaligned half off 3", size_half, 32'h13);
    for (int off = 1; off < 4; off++) begin
      add_store($sformatf("misaligned word off %0d", off), size_word, 32'h10 + off);
    end
    for (int w = 1; w < 5; w++) begin
      for (int off = 0; off < 4; off++) begin
        for (int s = 0; s < 3; s++) begin
          for (int sgn = 0; sgn < 2; sgn++) begin
            tag = $sformatf("%s %s load word %0d off %0d", sgn ? "signed" : "unsigned",
                            sizes[s].name(), w, off);
            add_load(tag, {sgn[0], sizes[s]}, w * 4 + off, 1'b1, 32'h0);
          end
        end
      end
    end
    add_store("led write a", size_word, addr_led);
    add_load("led read a", rd_word, addr_led, 1'b1, 32'h0);
    add_load("ram after led read", rd_word, 32'h14, 1'b1, 32'h0);
    add_store("led write b", size_byte, addr_led);
    add_load("led read b", rd_word, addr_led, 1'b1, 32'h0);
  endtask

  // one access, driven on a falling edge and ended on a later one
  task automatic run_access(input string name, input logic [2:0] rd, input size_e wr,
                            input logic [31:0] addr, input logic [31:0] din,
                            output logic [31:0] dout);
    int waited;
    @(negedge clk);
    enable     = 1'b1;
    read_type  = rd;
    write_type = wr;
    address    = addr;
    data_in    = din;
    dout       = 32'h0;
    #(period / 4);
    if (rd[1:0] == size_none) begin
      // a store is taken at the next rising edge
      @(negedge clk);
    end else if (is_io_addr(addr)) begin
      check_value({name, " ready"}, 32'h1, {31'b0, data_out_ready});
      dout = data_out;
      @(negedge clk);
    end else begin
      check_value({name, " early ready"}, 32'h0, {31'b0, data_out_ready});
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!data_out_ready && waited < 8);
      if (!data_out_ready) begin
        stop_with_failure($sformatf("no data_out_ready for the RAM load %s", name));
      end
      check_value({name, " latency"}, 32'd1, waited);
      dout = data_out;
    end
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = size_none;
  endtask

  task automatic apply_entry(input entry_t e);
    logic [31:0] data;
    logic [31:0] got;
    logic [31:0] expected;
    data = e.rnd ? rand_bits(32) : e.data;
    run_access(e.name, e.rd, e.wr, e.addr, data, got);
    if (e.wr != size_none) begin
      if (e.addr == addr_led) begin
        led_model = data[3:0];
        check_value({e.name, " led port"}, {28'b0, led_model}, {28'b0, led});
      end else begin
        model_store(e.wr, e.addr, data);
      end
    end else begin
      if (!e.use_model) begin
        expected = e.exp;
      end else if (e.addr == addr_led) begin
        expected = {28'b0, led_model};
      end else begin
        expected = model_load(e.rd, e.addr);
      end
      check_value(e.name, expected, got);
    end
  endtask

  // send a byte out and catch it again on the receive side
  task automatic uart_loopback(input logic [7:0] value);
    logic [31:0] got;
    int          polls;
    run_access("uart send", 3'b000, size_byte, addr_uart_out, {24'b0, value}, got);
    run_access("uart tx echo", rd_word, size_none, addr_uart_out, 32'h0, got);
    check_value("uart tx echo", {24'b0, value}, got);
    polls = 0;
    do begin
      run_access("uart tx poll", rd_word, size_none, addr_uart_out, 32'h0, got);
      polls++;
    end while (got !== io_idle && polls < frame_cycles);
    if (got !== io_idle) begin
      stop_with_failure("transmit register never went back to idle after the frame");
    end
    run_access("uart rx read", rd_word, size_none, addr_uart_in, 32'h0, got);
    check_value("uart rx read", {24'b0, value}, got);
    run_access("uart rx cleared", rd_word, size_none, addr_uart_in, 32'h0, got);
    check_value("uart rx cleared", io_idle, got);
  endtask

  initial begin
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = size_none;
    address    = 32'h0;
    data_in    = 32'h0;
    led_model  = 4'b1111;
    lfsr_state = 32'hca988c5a;
    build_table();
    table_built = 1'b1;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("reset uart_tx", 32'h1, {31'b0, uart_line});
    check_value("reset led port", 32'hf, {28'b0, led});
    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    for (int n = 0; n < 4; n++) begin
      uart_loopback(8'(rand_bits(8)));
    end
    @(negedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // table length times 20 cycles plus 40 frames
  initial begin
    wait (table_built);
    repeat (stim.size() * 20 + 40 * frame_cycles) @(posedge clk);
    stop_with_failure("watchdog expired before the tests finished");
  end

  always @(dut.checks.failures) begin
    if (dut.checks.failures != 0) begin
      stop_with_failure("a bound assertion on the DUT failed");
    end
  end

endmodule

`default_nettype wire

// File: tests/ramio_sva.sv
// concurrent checks on the memory-mapped port, bound into ramio
// covers RAM read timing, the idle transmit line and the LED reset value
`timescale 1ns/1ps
`default_nettype none

module ramio_sva import ramio_pkg::*; (
  input wire        clk,
  input wire        rst_n,
  input wire        enable,
  input wire [2:0]  read_type,
  input wire [31:0] address,
  input wire        data_out_ready,
  input wire        tx_busy,
  input wire        tx_go,
  input wire        uart_tx,
  input wire [3:0]  led
);

  // assertion failures seen so far
  int unsigned failures = 0;

  logic ram_load;

  // a load to any address outside the three I/O words
  assign ram_load = enable && (read_type[1:0] != size_none) &&
                    (address != addr_led) && (address != addr_uart_out) &&
                    (address != addr_uart_in);

  // a RAM load is answered in the very next cycle
  ram_read_ready: assert property (
    @(posedge clk) disable iff (!rst_n) ram_load |=> data_out_ready
  ) else begin
    $error("data_out_ready did not follow a RAM read by one cycle");
    failures++;
  end

  // line stays at the idle level with no frame going out
  tx_line_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (!tx_busy && !tx_go) |-> uart_tx
  ) else begin
    $error("uart_tx low while no transmission is pending");
    failures++;
  end

  // every reset cycle leaves all LEDs off
  led_after_reset: assert property (
    @(posedge clk) !rst_n |=> (led == 4'b1111)
  ) else begin
    $error("led not all ones after reset");
    failures++;
  end

endmodule

bind ramio ramio_sva checks (
  .clk(clk),
  .rst_n(rst_n),
  .enable(enable),
  .read_type(read_type),
  .address(address),
  .data_out_ready(data_out_ready),
  .tx_busy(tx_busy),
  .tx_go(tx_go),
  .uart_tx(uart_tx),
  .led(led)
);

`default_nettype wire

// File: tests/tb_clock.sv
// clock and reset source for the testbench
// free-running clock, rst_n held low for the first cycles and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period       = 40,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: source/ramio.sv
// memory-mapped port for a small processor
// one client port for sized loads and stores, routed to the word RAM
// or to the LED, UART transmit and UART receive registers
`timescale 1ns/1ps
`default_nettype none

module ramio import ramio_pkg::*; #(
  parameter int ram_addr_bits = 10,
  parameter int clks_per_bit  = 217
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         enable,
  input  wire  [2:0]  read_type,
  input  wire  size_e write_type,
  input  wire  [31:0] address,
  input  wire  [31:0] data_in,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic [3:0]  led,
  output logic        uart_tx,
  input  wire         uart_rx
);

  logic        is_rd;
  logic        is_wr;
  logic        io_hit;
  logic        ram_req;
  logic        rx_rd;
  logic        rd_pending;
  logic [31:0] ram_data;
  logic [31:0] tx_reg;
  logic [31:0] rx_reg;
  logic        tx_go;
  logic        tx_busy;
  logic        tx_busy_q;
  logic [7:0]  rx_data;
  logic        rx_ready;
  logic        rx_ack;

  ram_if #(.ram_addr_bits(ram_addr_bits)) ram ();

  assign is_rd  = (read_type[1:0] != size_none);
  assign is_wr  = (write_type != size_none);
  assign io_hit = (address == addr_led) || (address == addr_uart_out) ||
                  (address == addr_uart_in);

  // everything outside the I/O words goes to RAM, upper bits alias
  assign ram_req       = enable && !io_hit && (is_rd || is_wr);
  assign ram.en        = ram_req;
  assign ram.word_addr = address[ram_addr_bits+1:2];

  assign rx_rd = enable && is_rd && (address == addr_uart_in);
  // a read of the receive register wins, the byte waits in uart_rx
  assign rx_ack = rx_ready && !rx_rd;

  // I/O answers at once, RAM one cycle later
  assign data_out_ready = (enable && io_hit) || rd_pending;

  always_comb begin
    data_out = ram_data;
    if (enable && is_rd) begin
      if (address == addr_uart_out) begin
        data_out = tx_reg;
      end else if (address == addr_uart_in) begin
        data_out = rx_reg;
      end else if (address == addr_led) begin
        data_out = {28'b0, led};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
      led        <= 4'b1111;
      tx_reg     <= io_idle;
      tx_go      <= 1'b0;
      tx_busy_q  <= 1'b0;
      rx_reg     <= io_idle;
    end else begin
      rd_pending <= ram_req && is_rd;
      tx_busy_q  <= tx_busy;
      tx_go      <= 1'b0;
      if (enable && is_wr && (address == addr_led)) begin
        led <= data_in[3:0];
      end
      // the register shows the byte until the frame has gone out
      if (enable && is_wr && (address == addr_uart_out)) begin
        tx_reg <= {24'b0, data_in[7:0]};
        tx_go  <= 1'b1;
      end else if (tx_busy_q && !tx_busy) begin
        tx_reg <= io_idle;
      end
      if (rx_rd) begin
        rx_reg <= io_idle;
      end else if (rx_ack) begin
        rx_reg <= {24'b0, rx_data};
      end
    end
  end

  lane_steer steer (
    .clk,
    .rst_n,
    .ram(ram.requester),
    .req(ram_req),
    .read_type,
    .write_type,
    .address,
    .data_in,
    .data_out(ram_data)
  );

  word_ram #(.ram_addr_bits(ram_addr_bits)) mem_block (
    .clk,
    .mem(ram.memory)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) tx_unit (
    .clk,
    .rst_n,
    .data(tx_reg[7:0]),
    .go(tx_go),
    .busy(tx_busy),
    .tx(uart_tx)
  );

  uart_rx #(.clks_per_bit(clks_per_bit)) rx_unit (
    .clk,
    .rst_n,
    .rx(uart_rx),
    .ack(rx_ack),
    .data(rx_data),
    .data_ready(rx_ready)
  );

endmodule

`default_nettype wire

// File: source/uart_rx.sv
// UART receiver for 8N1 frames
// data_ready is a level raised mid stop bit and held until ack
`timescale 1ns/1ps
`default_nettype none

module uart_rx import ramio_pkg::*; #(
  parameter int clks_per_bit = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        ack,
  output logic [7:0] data,
  output logic       data_ready
);

  logic [1:0] sync;
  logic       rx_s;
  rx_state_e  state;
  logic [7:0] shift;
  logic [2:0] bit_cnt;
  logic       bit_mid;

  // two flops against metastability, idle line is high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rx};
    end
  end

  assign rx_s = sync[1];

  // timer starts from the falling edge of the start bit
  bit_timer #(.clks_per_bit(clks_per_bit)) timer (
    .clk,
    .rst_n,
    .clear(state == rx_idle),
    .mid_tick(bit_mid),
    .end_tick()
  );

  assign data_ready = (state == rx_hold);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= rx_idle;
      bit_cnt <= 3'd0;
    end else begin
      unique case (state)
        rx_idle: if (!rx_s) state <= rx_start;
        rx_start: begin
          // a glitch shorter than half a bit goes back to idle
          if (bit_mid) begin
            state   <= rx_s ? rx_idle : rx_data;
            bit_cnt <= 3'd0;
          end
        end
        rx_data: begin
          if (bit_mid) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          // framing error drops the byte
          if (bit_mid) begin
            state <= rx_s ? rx_hold : rx_idle;
          end
        end
        rx_hold: if (ack) state <= rx_idle;
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_data && bit_mid) begin
      shift <= {rx_s, shift[7:1]};
    end
    if (state == rx_stop && bit_mid && rx_s) begin
      data <= shift;
    end
  end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
// UART transmitter for 8N1 frames
// a go pulse in idle latches data, the frame starts on the next cycle
`timescale 1ns/1ps
`default_nettype none

module uart_tx import ramio_pkg::*; #(
  parameter int clks_per_bit = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] data,
  input  wire        go,
  output logic       busy,
  output logic       tx
);

  tx_state_e  state;
  logic [7:0] shift;
  logic [2:0] bit_cnt;
  logic       bit_end;

  // timer held at zero while idle so the start bit gets a full period
  bit_timer #(.clks_per_bit(clks_per_bit)) timer (
    .clk,
    .rst_n,
    .clear(state == tx_idle),
    .mid_tick(),
    .end_tick(bit_end)
  );

  assign busy = (state != tx_idle);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= tx_idle;
      tx      <= 1'b1;
      bit_cnt <= 3'd0;
    end else begin
      unique case (state)
        tx_idle: begin
          if (go) begin
            state <= tx_start;
            tx    <= 1'b0;
          end
        end
        tx_start: begin
          if (bit_end) begin
            state   <= tx_data;
            tx      <= shift[0];
            bit_cnt <= 3'd0;
          end
        end
        tx_data: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              state <= tx_stop;
              tx    <= 1'b1;
            end else begin
              tx      <= shift[0];
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
        end
        tx_stop: begin
          if (bit_end) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // lsb first, shifted as each bit goes out
  always_ff @(posedge clk) begin
    if (state == tx_idle && go) begin
      shift <= data;
    end else if (bit_end && (state == tx_start || state == tx_data)) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: source/word_ram.sv
// on-chip word RAM with per-byte write enables
// a read is a request with no enables set, data comes one cycle later
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
  parameter int ram_addr_bits = 10
) (
  input wire     clk,
  ram_if.memory  mem
);

  logic [31:0] store [2**ram_addr_bits];

  always_ff @(posedge clk) begin
    if (mem.en) begin
      for (int i = 0; i < 4; i++) begin
        if (mem.we[i]) begin
          store[mem.word_addr][8*i +: 8] <= mem.wdata[8*i +: 8];
        end
      end
      // rdata holds its value between reads
      if (mem.we == 4'b0000) begin
        mem.rdata <= store[mem.word_addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lane_steer.sv
// byte lane steering between the client port and the word RAM
// stores become byte-enabled word writes, loads are extracted and
// extended in the cycle after the request
`timescale 1ns/1ps
`default_nettype none

module lane_steer import ramio_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  ram_if.requester     ram,
  input  wire          req,
  input  wire   [2:0]  read_type,
  input  wire   size_e write_type,
  input  wire   [31:0] address,
  input  wire   [31:0] data_in,
  output logic  [31:0] data_out
);

  size_e       rd_size;
  logic        rd_signed;
  logic [1:0]  rd_lo;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  // store data goes to every lane, the enables pick the ones written
  always_comb begin
    ram.we    = 4'b0000;
    ram.wdata = data_in;
    if (req) begin
      unique case (write_type)
        size_byte: begin
          ram.we    = 4'b0001 << address[1:0];
          ram.wdata = {4{data_in[7:0]}};
        end
        size_half: begin
          ram.wdata = {2{data_in[15:0]}};
          // odd half-word address gives no enables
          if (!address[0]) begin
            ram.we = address[1] ? 4'b1100 : 4'b0011;
          end
        end
        size_word: begin
          if (address[1:0] == 2'b00) begin
            ram.we = 4'b1111;
          end
        end
        default: ;
      endcase
    end
  end

  // remember how to cut the load out of next cycle's rdata
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_size   <= size_none;
      rd_signed <= 1'b0;
      rd_lo     <= 2'b00;
    end else begin
      rd_size   <= req ? size_e'(read_type[1:0]) : size_none;
      rd_signed <= read_type[2];
      rd_lo     <= address[1:0];
    end
  end

  assign rd_byte = ram.rdata[{rd_lo, 3'b000} +: 8];
  assign rd_half = rd_lo[1] ? ram.rdata[31:16] : ram.rdata[15:0];

  always_comb begin
    data_out = 32'b0;
    unique case (rd_size)
      size_byte: data_out = {{24{rd_signed & rd_byte[7]}}, rd_byte};
      size_half: begin
        if (!rd_lo[0]) begin
          data_out = {{16{rd_signed & rd_half[15]}}, rd_half};
        end
      end
      size_word: begin
        if (rd_lo == 2'b00) begin
          data_out = ram.rdata;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/bit_timer.sv
// serial bit period timer shared by the UART transmitter and receiver
// counts clks_per_bit cycles from a clear and then wraps
`timescale 1ns/1ps
`default_nettype none

module bit_timer #(
  parameter int clks_per_bit = 8
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  clear,
  output logic mid_tick,
  output logic end_tick
);

  localparam int cnt_bits = $clog2(clks_per_bit);

  logic [cnt_bits-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      count <= '0;
    end else if (end_tick) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // half way through the bit, where the receiver samples
  assign mid_tick = (count == cnt_bits'(clks_per_bit / 2 - 1));
  assign end_tick = (count == cnt_bits'(clks_per_bit - 1));

endmodule

`default_nettype wire

// File: source/ram_if.sv
// RAM access bundle between the requester side and the word RAM
// the requester drives the request, the memory returns read data
`timescale 1ns/1ps
`default_nettype none

interface ram_if #(
  parameter int ram_addr_bits = 10
);
  logic                     en;
  logic [3:0]               we;         // one enable per byte lane
  logic [ram_addr_bits-1:0] word_addr;
  logic [31:0]              wdata;
  logic [31:0]              rdata;      // valid the cycle after a read

  modport requester (output en, output we, output word_addr, output wdata, input rdata);
  modport memory (input en, input we, input word_addr, input wdata, output rdata);
endinterface

`default_nettype wire

// File: source/ramio_pkg.sv
// shared types and constants for the memory-mapped port
// imported by the blocks that need access sizes, UART states or the I/O map
`default_nettype none

package ramio_pkg;

  // access size, also the low two bits of read_type
  typedef enum logic [1:0] {
    size_none = 2'b00,
    size_byte = 2'b01,
    size_half = 2'b10,
    size_word = 2'b11
  } size_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_hold
  } rx_state_e;

  // I/O registers at the top of the address space
  localparam logic [31:0] addr_led      = 32'hffff_fffc;
  localparam logic [31:0] addr_uart_out = 32'hffff_fff8;
  localparam logic [31:0] addr_uart_in  = 32'hffff_fff4;

  // uart registers read this when there is nothing to report
  localparam logic [31:0] io_idle = 32'hffff_ffff;

endpackage

`default_nettype wire
